// ==== hw/ch2_defs.svh ====
`ifndef CH2_DEFS_SVH
`define CH2_DEFS_SVH

// amuk_4mhz clocks per 512 Hz frame sequencer tick
`define CH2_FRAME_DIV 8192

// amuk_4mhz clocks per count of the 11-bit period timer
`define CH2_FREQ_PRESCALE 4

`define CH2_ADDR_NR21 2'd0
`define CH2_ADDR_NR22 2'd1
`define CH2_ADDR_NR23 2'd2
`define CH2_ADDR_NR24 2'd3

`endif

// ==== hw/ch2_pkg.sv ====
package ch2_pkg;

	// 0 is 1/8 high, 1 is 2/8, 2 is 4/8, 3 is 6/8
	typedef logic [1:0] duty_t;

	// envelope volume, also the channel amplitude
	typedef logic [3:0] vol_t;

	// a period of 0 freezes the envelope
	typedef logic [2:0] env_period_t;

	// the channel plays for 64 minus this many length ticks
	typedef logic [5:0] length_t;

	typedef logic [10:0] freq_t;

endpackage

// ==== hw/ch2_regs.sv ====
`timescale 1ns/1ns
`include "ch2_defs.svh"

module ch2_regs import ch2_pkg::*; (
	input  logic        amuk_4mhz,
	input  logic        arst_n,
	input  logic        wr,
	input  logic [1:0]  addr,
	input  logic [7:0]  wdata,
	output duty_t       duty,
	output length_t     len_load,
	output logic        len_write,
	output vol_t        vol_init,
	output logic        env_up,
	output env_period_t env_period,
	output freq_t       freq,
	output logic        len_en,
	output logic        trigger
);

	always_ff @(posedge amuk_4mhz or negedge arst_n) begin
		if (!arst_n) begin
			duty       <= '0;
			len_load   <= '0;
			len_write  <= 1'b0;
			vol_init   <= '0;
			env_up     <= 1'b0;
			env_period <= '0;
			freq       <= '0;
			len_en     <= 1'b0;
			trigger    <= 1'b0;
		end else begin
			len_write <= 1'b0;
			trigger   <= 1'b0;
			if (wr) begin
				case (addr)
					`CH2_ADDR_NR21: begin
						duty      <= wdata[7:6];
						// kept complemented so the length counter loads 64 - L after +1
						len_load  <= ~wdata[5:0];
						len_write <= 1'b1;
					end
					`CH2_ADDR_NR22: begin
						vol_init   <= wdata[7:4];
						env_up     <= wdata[3];
						env_period <= wdata[2:0];
					end
					`CH2_ADDR_NR23: begin
						freq[7:0] <= wdata;
					end
					`CH2_ADDR_NR24: begin
						freq[10:8] <= wdata[2:0];
						len_en     <= wdata[6];
						trigger    <= wdata[7];
					end
				endcase
			end
		end
	end

endmodule

// ==== hw/ch2_control.sv ====
`timescale 1ns/1ns
`include "ch2_defs.svh"

module ch2_control import ch2_pkg::*; #(
	parameter int FRAME_DIV = `CH2_FRAME_DIV
) (
	input  logic amuk_4mhz,
	input  logic arst_n,
	input  logic trigger,
	input  vol_t vol_init,
	input  logic env_up,
	input  logic len_en,
	input  logic len_expired,
	output logic restart,
	output logic len_tick,
	output logic env_tick,
	output logic ch2_active
);

	localparam int DIV_W = $clog2(FRAME_DIV);

	logic [DIV_W-1:0] frame_div;
	logic [2:0]       frame_step;
	logic             frame_tick;
	logic             dac_en;

	assign frame_tick = (frame_div == DIV_W'(FRAME_DIV - 1));

	// the DAC is off when the upper five bits of NR22 are all zero
	assign dac_en = (vol_init != '0) || env_up;

	// 512 Hz frame ticks, stepped down to 256 Hz length and 64 Hz envelope ticks
	always_ff @(posedge amuk_4mhz or negedge arst_n) begin
		if (!arst_n) begin
			frame_div  <= '0;
			frame_step <= '0;
			len_tick   <= 1'b0;
			env_tick   <= 1'b0;
		end else begin
			if (frame_tick) begin
				frame_div  <= '0;
				frame_step <= frame_step + 3'd1;
			end else begin
				frame_div <= frame_div + 1'b1;
			end
			len_tick <= frame_tick && frame_step[0];
			env_tick <= frame_tick && (frame_step == 3'd7);
		end
	end

	always_ff @(posedge amuk_4mhz or negedge arst_n) begin
		if (!arst_n) begin
			restart    <= 1'b0;
			ch2_active <= 1'b0;
		end else begin
			restart <= trigger && dac_en;
			if (!dac_en) begin
				ch2_active <= 1'b0;
			end else if (trigger) begin
				// a retrigger wins over a length expiry in the same cycle
				ch2_active <= 1'b1;
			end else if (len_en && len_expired) begin
				ch2_active <= 1'b0;
			end
		end
	end

endmodule

// ==== hw/ch2_down_counter.sv ====
`timescale 1ns/1ns

module ch2_down_counter import ch2_pkg::*; #(
	parameter type count_t = length_t
) (
	input  logic   amuk_4mhz,
	input  logic   arst_n,
	input  logic   load,
	input  count_t load_value,
	input  logic   tick,
	output logic   expired
);

	count_t count;

	always_ff @(posedge amuk_4mhz or negedge arst_n) begin
		if (!arst_n) begin
			count   <= '0;
			expired <= 1'b0;
		end else begin
			expired <= 1'b0;
			if (load) begin
				count <= load_value;
			end else if (tick && (count != '0)) begin
				count <= count - count_t'(1);
				// only the tick that takes the count from 1 to 0 flags expiry
				if (count == count_t'(1))
					expired <= 1'b1;
			end
		end
	end

endmodule

// ==== hw/ch2_freq_timer.sv ====
`timescale 1ns/1ns
`include "ch2_defs.svh"

module ch2_freq_timer import ch2_pkg::*; (
	input  logic  amuk_4mhz,
	input  logic  arst_n,
	input  freq_t freq,
	input  logic  restart,
	output logic  step
);

	localparam int PRE_W = $clog2(`CH2_FREQ_PRESCALE + 1);

	logic [PRE_W-1:0] prescale;
	freq_t            period_cnt;
	logic             pre_end;

	assign pre_end = (prescale == PRE_W'(`CH2_FREQ_PRESCALE - 1));

	// counts up from freq to 2047, so one step lasts (2048 - freq) prescaled counts
	always_ff @(posedge amuk_4mhz or negedge arst_n) begin
		if (!arst_n) begin
			prescale   <= '0;
			period_cnt <= '0;
			step       <= 1'b0;
		end else begin
			step <= 1'b0;
			if (restart) begin
				prescale   <= '0;
				period_cnt <= freq;
			end else if (pre_end) begin
				prescale <= '0;
				if (period_cnt == '1) begin
					period_cnt <= freq;
					step       <= 1'b1;
				end else begin
					period_cnt <= period_cnt + 1'b1;
				end
			end else begin
				prescale <= prescale + 1'b1;
			end
		end
	end

endmodule

// ==== hw/ch2_envelope.sv ====
`timescale 1ns/1ns

module ch2_envelope import ch2_pkg::*; (
	input  logic        amuk_4mhz,
	input  logic        arst_n,
	input  logic        restart,
	input  logic        env_tick,
	input  vol_t        vol_init,
	input  logic        env_up,
	input  env_period_t env_period,
	output vol_t        vol
);

	logic period_expired;

	// reloaded on every expiry, and ticks are ignored while the period is 0
	ch2_down_counter #(
		.count_t(env_period_t)
	) period_cnt_inst (
		.amuk_4mhz  (amuk_4mhz),
		.arst_n     (arst_n),
		.load       (restart || period_expired),
		.load_value (env_period),
		.tick       (env_tick && (env_period != '0)),
		.expired    (period_expired)
	);

	always_ff @(posedge amuk_4mhz or negedge arst_n) begin
		if (!arst_n) begin
			vol <= '0;
		end else if (restart) begin
			vol <= vol_init;
		end else if (period_expired && (env_period != '0)) begin
			if (env_up && (vol != 4'd15))
				vol <= vol + 4'd1;
			else if (!env_up && (vol != 4'd0))
				vol <= vol - 4'd1;
		end
	end

endmodule

// ==== hw/ch2_waveform.sv ====
`timescale 1ns/1ns

module ch2_waveform import ch2_pkg::*; (
	input  logic  amuk_4mhz,
	input  logic  arst_n,
	input  logic  restart,
	input  logic  step,
	input  duty_t duty,
	input  vol_t  vol,
	input  logic  ch2_active,
	output vol_t  ch2_out
);

	logic [2:0] step_idx;
	logic [2:0] step_idx_next;

	function automatic logic duty_bit(duty_t sel, logic [2:0] idx);
		logic [7:0] pattern;
		case (sel)
			2'd0:    pattern = 8'b1000_0000;
			2'd1:    pattern = 8'b1000_0001;
			2'd2:    pattern = 8'b1110_0001;
			default: pattern = 8'b0111_1110;
		endcase
		return pattern[idx];
	endfunction

	// the output looks at the next index so a step shows up one cycle later
	assign step_idx_next = restart ? 3'd0 : (step ? step_idx + 3'd1 : step_idx);

	always_ff @(posedge amuk_4mhz or negedge arst_n) begin
		if (!arst_n) begin
			step_idx <= '0;
			ch2_out  <= '0;
		end else begin
			step_idx <= step_idx_next;
			ch2_out  <= (duty_bit(duty, step_idx_next) && ch2_active) ? vol : '0;
		end
	end

endmodule

// ==== hw/ch2_top.sv ====
`timescale 1ns/1ns
`include "ch2_defs.svh"

module ch2_top import ch2_pkg::*; #(
	parameter int FRAME_DIV = `CH2_FRAME_DIV
) (
	input  logic       amuk_4mhz,
	input  logic       arst_n,
	input  logic       wr,
	input  logic [1:0] addr,
	input  logic [7:0] wdata,
	output vol_t       ch2_out,
	output logic       ch2_active
);

	// one bit wider than length_t so that a full 64-tick count fits
	typedef logic [6:0] len_count_t;

	duty_t       duty;
	length_t     len_load;
	logic        len_write;
	vol_t        vol_init;
	logic        env_up;
	env_period_t env_period;
	freq_t       freq;
	logic        len_en;
	logic        trigger;
	logic        restart;
	logic        len_tick;
	logic        env_tick;
	logic        len_expired;
	logic        step;
	vol_t        vol;
	len_count_t  len_load_value;

	assign len_load_value = len_count_t'({1'b0, len_load}) + 7'd1;

	ch2_regs ch2_regs_inst (
		.amuk_4mhz  (amuk_4mhz),
		.arst_n     (arst_n),
		.wr         (wr),
		.addr       (addr),
		.wdata      (wdata),
		.duty       (duty),
		.len_load   (len_load),
		.len_write  (len_write),
		.vol_init   (vol_init),
		.env_up     (env_up),
		.env_period (env_period),
		.freq       (freq),
		.len_en     (len_en),
		.trigger    (trigger)
	);

	ch2_control #(
		.FRAME_DIV(FRAME_DIV)
	) ch2_control_inst (
		.amuk_4mhz   (amuk_4mhz),
		.arst_n      (arst_n),
		.trigger     (trigger),
		.vol_init    (vol_init),
		.env_up      (env_up),
		.len_en      (len_en),
		.len_expired (len_expired),
		.restart     (restart),
		.len_tick    (len_tick),
		.env_tick    (env_tick),
		.ch2_active  (ch2_active)
	);

	// length only counts while NR24 bit 6 is set
	ch2_down_counter #(
		.count_t(len_count_t)
	) len_cnt_inst (
		.amuk_4mhz  (amuk_4mhz),
		.arst_n     (arst_n),
		.load       (len_write || restart),
		.load_value (len_load_value),
		.tick       (len_tick && len_en),
		.expired    (len_expired)
	);

	ch2_freq_timer ch2_freq_timer_inst (
		.amuk_4mhz (amuk_4mhz),
		.arst_n    (arst_n),
		.freq      (freq),
		.restart   (restart),
		.step      (step)
	);

	ch2_envelope ch2_envelope_inst (
		.amuk_4mhz  (amuk_4mhz),
		.arst_n     (arst_n),
		.restart    (restart),
		.env_tick   (env_tick),
		.vol_init   (vol_init),
		.env_up     (env_up),
		.env_period (env_period),
		.vol        (vol)
	);

	ch2_waveform ch2_waveform_inst (
		.amuk_4mhz  (amuk_4mhz),
		.arst_n     (arst_n),
		.restart    (restart),
		.step       (step),
		.duty       (duty),
		.vol        (vol),
		.ch2_active (ch2_active),
		.ch2_out    (ch2_out)
	);

endmodule

// ==== sim/tb_ch2.sv ====
`timescale 1ns/1ns
`include "ch2_defs.svh"

module tb_ch2 import ch2_pkg::*; #(
	parameter int FRAME_DIV = `CH2_FRAME_DIV
);

	localparam int HALF_PERIOD = 20;
	localparam int DRIVE_DELAY = 2;
	localparam int PRESCALE    = `CH2_FREQ_PRESCALE;
	localparam int LEN_PERIOD  = 2 * FRAME_DIV;
	localparam int ENV_UNIT    = 8 * FRAME_DIV;
	localparam int NUM_ROWS    = 10;

	localparam logic [2:0] K_DUTY     = 3'd0;
	localparam logic [2:0] K_DAC_OFF  = 3'd1;
	localparam logic [2:0] K_LEN_EXP  = 3'd2;
	localparam logic [2:0] K_LEN_HOLD = 3'd3;
	localparam logic [2:0] K_ENV_DOWN = 3'd4;
	localparam logic [2:0] K_ENV_UP   = 3'd5;
	localparam logic [2:0] K_RETRIG   = 3'd6;

	typedef struct packed {
		duty_t       duty;
		vol_t        vol;
		logic        env_up;
		env_period_t per;
		length_t     len;
		logic        len_en;
		freq_t       freq;
		logic [2:0]  high_steps;
		logic [2:0]  kind;
	} row_t;

	logic        amuk_4mhz;
	logic        arst_n;
	logic        wr;
	logic [1:0]  addr;
	logic [7:0]  wdata;
	vol_t        ch2_out;
	logic        ch2_active;
	logic [31:0] lcg_state;
	row_t        rows [NUM_ROWS];

	ch2_top #(
		.FRAME_DIV(FRAME_DIV)
	) ch2_top_inst (
		.amuk_4mhz  (amuk_4mhz),
		.arst_n     (arst_n),
		.wr         (wr),
		.addr       (addr),
		.wdata      (wdata),
		.ch2_out    (ch2_out),
		.ch2_active (ch2_active)
	);

	initial begin
		amuk_4mhz = 1'b0;
		forever #HALF_PERIOD amuk_4mhz = ~amuk_4mhz;
	end

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	// step lengths from 16 to 124 clocks keep one waveform period short
	function automatic freq_t pick_freq(input logic [31:0] s);
		return freq_t'(2044 - int'(s[23:16]) % 28);
	endfunction

	function automatic logic [2:0] high_steps_for(input int d);
		case (d)
			0:       return 3'd1;
			1:       return 3'd2;
			2:       return 3'd4;
			default: return 3'd6;
		endcase
	endfunction

	task automatic stop_sim();
		$display("TEST FAILED");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic check_val(input string name, input int expected, input int actual);
		assert (actual == expected) else begin
			$display("FAIL at %0t ns: %s expected %0d, got %0d", $time, name, expected, actual);
			stop_sim();
		end
	endtask

	task automatic check_near(input string name, input int expected, input int tol,
			input int actual);
		assert (actual >= expected - tol && actual <= expected + tol) else begin
			$display("FAIL at %0t ns: %s expected %0d +/- %0d, got %0d", $time, name,
				expected, tol, actual);
			stop_sim();
		end
	endtask

	task automatic check_timeout(input logic ok, input string what);
		assert (ok) else begin
			$display("timeout while waiting for %s", what);
			stop_sim();
		end
	endtask

	task automatic next_cycle();
		@(posedge amuk_4mhz);
		#DRIVE_DELAY;
	endtask

	task automatic write_reg(input logic [1:0] a, input logic [7:0] d);
		addr  = a;
		wdata = d;
		wr    = 1'b1;
		next_cycle();
		wr    = 1'b0;
	endtask

	task automatic apply_row(input row_t r);
		write_reg(`CH2_ADDR_NR21, {r.duty, r.len});
		write_reg(`CH2_ADDR_NR22, {r.vol, r.env_up, r.per});
		write_reg(`CH2_ADDR_NR23, r.freq[7:0]);
		write_reg(`CH2_ADDR_NR24, {1'b1, r.len_en, 3'b000, r.freq[10:8]});
	endtask

	// ch2_active is due two cycles after the NR24 write
	task automatic after_trigger();
		next_cycle();
		check_val("ch2_active", 1, int'(ch2_active));
		next_cycle();
	endtask

	task automatic check_duty(input row_t r);
		int step_len;
		int high_cnt;
		step_len = (2048 - int'(r.freq)) * PRESCALE;
		high_cnt = 0;
		// the first output after restart still carries the volume from before the trigger
		next_cycle();
		for (int i = 0; i < 8 * step_len; i++) begin
			if (ch2_out == r.vol)
				high_cnt++;
			else
				check_val("ch2_out", 0, int'(ch2_out));
			next_cycle();
		end
		check_near("ch2_out high cycles", int'(r.high_steps) * step_len, step_len - 1,
			high_cnt);
	endtask

	task automatic check_dac_off();
		for (int i = 0; i < 32; i++) begin
			next_cycle();
			check_val("ch2_active", 0, int'(ch2_active));
			check_val("ch2_out", 0, int'(ch2_out));
		end
	endtask

	// n counts cycles since the NR24 write that started the length count
	task automatic measure_fall(input int lo, input int hi, input int start);
		int n;
		n = start;
		while (ch2_active === 1'b1 && n <= hi) begin
			next_cycle();
			n++;
		end
		check_timeout(ch2_active === 1'b0, "ch2_active to fall at length expiry");
		check_near("ch2_active fall cycle", (lo + hi) / 2, (hi - lo) / 2, n);
	endtask

	task automatic check_length(input row_t r);
		int lo;
		int hi;
		lo = (63 - int'(r.len)) * LEN_PERIOD;
		hi = (64 - int'(r.len)) * LEN_PERIOD + 8;
		if (r.kind == K_LEN_EXP) begin
			measure_fall(lo, hi, 2);
		end else begin
			for (int n = 2; n < hi + LEN_PERIOD; n++) begin
				next_cycle();
				check_val("ch2_active", 1, int'(ch2_active));
			end
		end
	endtask

	task automatic track_env(input row_t r);
		int step_len;
		int n;
		int level;
		int expected;
		int changes;
		int last_change;
		int zero_run;
		int hold;
		int limit;
		logic done;
		step_len    = (2048 - int'(r.freq)) * PRESCALE;
		limit       = (16 * int'(r.per) + 4) * ENV_UNIT;
		n           = 2;
		level       = 0;
		changes     = 0;
		last_change = 0;
		zero_run    = 0;
		hold        = 0;
		done        = 1'b0;
		while (!done && n < limit) begin
			if (ch2_out != 4'd0) begin
				zero_run = 0;
				if (int'(ch2_out) != level) begin
					if (level == 0)
						expected = int'(r.vol);
					else if (r.env_up)
						expected = level + 1;
					else
						expected = level - 1;
					check_val("ch2_out", expected, int'(ch2_out));
					// the first change lands at an arbitrary point of the env_tick period
					if (changes >= 2)
						check_near("envelope step spacing", ENV_UNIT * int'(r.per),
							FRAME_DIV, n - last_change);
					last_change = n;
					changes++;
					level = int'(ch2_out);
				end
			end else begin
				zero_run++;
			end
			// a climbing volume never leaves a whole waveform period silent
			if (r.env_up && zero_run > 8 * step_len)
				check_val("ch2_out", level, int'(ch2_out));
			if (r.env_up && level == 15)
				hold++;
			done = r.env_up ? (hold > 2 * ENV_UNIT * int'(r.per)) :
				(level == 1 && zero_run > 8 * step_len);
			next_cycle();
			n++;
		end
		check_timeout(done, "the envelope to reach its limit");
	endtask

	task automatic retrigger(input row_t r);
		int step_len;
		int n;
		step_len = (2048 - int'(r.freq)) * PRESCALE;
		n = 0;
		while (!(ch2_out != 4'd0 && int'(ch2_out) < int'(r.vol)) &&
				n < 4 * ENV_UNIT * int'(r.per)) begin
			check_val("ch2_active", 1, int'(ch2_active));
			next_cycle();
			n++;
		end
		check_timeout(ch2_out != 4'd0 && int'(ch2_out) < int'(r.vol), "the envelope to drop");
		write_reg(`CH2_ADDR_NR24, {2'b11, 3'b000, r.freq[10:8]});
		after_trigger();
		n = 2;
		while (ch2_out == 4'd0 && n < 2 + 16 * step_len) begin
			check_val("ch2_active", 1, int'(ch2_active));
			next_cycle();
			n++;
		end
		check_timeout(ch2_out != 4'd0, "ch2_out after the retrigger");
		check_val("ch2_out", int'(r.vol), int'(ch2_out));
		measure_fall((63 - int'(r.len)) * LEN_PERIOD, (64 - int'(r.len)) * LEN_PERIOD + 8, n);
	endtask

	initial begin
		arst_n    = 1'b0;
		wr        = 1'b0;
		addr      = '0;
		wdata     = '0;
		lcg_state = 32'hd2b1;
		for (int i = 0; i < 4; i++) begin
			lcg_state = lcg_next(lcg_state);
			rows[i] = '{duty_t'(i), 4'd9, 1'b0, 3'd0, 6'd0, 1'b0, pick_freq(lcg_state),
				high_steps_for(i), K_DUTY};
		end
		rows[4] = '{2'd0, 4'd0, 1'b0, 3'd0, 6'd0, 1'b0, 11'd2040, 3'd0, K_DAC_OFF};
		rows[5] = '{2'd2, 4'd7, 1'b0, 3'd0, 6'd60, 1'b1, 11'd2040, 3'd4, K_LEN_EXP};
		rows[6] = '{2'd2, 4'd7, 1'b0, 3'd0, 6'd60, 1'b0, 11'd2040, 3'd4, K_LEN_HOLD};
		rows[7] = '{2'd3, 4'd4, 1'b0, 3'd2, 6'd0, 1'b0, 11'd2044, 3'd6, K_ENV_DOWN};
		rows[8] = '{2'd3, 4'd12, 1'b1, 3'd2, 6'd0, 1'b0, 11'd2044, 3'd6, K_ENV_UP};
		rows[9] = '{2'd3, 4'd10, 1'b0, 3'd2, 6'd50, 1'b1, 11'd2044, 3'd6, K_RETRIG};

		repeat (16) @(posedge amuk_4mhz);
		#DRIVE_DELAY;
		arst_n = 1'b1;
		check_val("ch2_out", 0, int'(ch2_out));
		check_val("ch2_active", 0, int'(ch2_active));
		next_cycle();
		check_val("ch2_out", 0, int'(ch2_out));
		check_val("ch2_active", 0, int'(ch2_active));

		for (int i = 0; i < NUM_ROWS; i++) begin
			apply_row(rows[i]);
			if (rows[i].kind == K_DAC_OFF) begin
				check_dac_off();
			end else begin
				after_trigger();
				case (rows[i].kind)
					K_DUTY:                check_duty(rows[i]);
					K_LEN_EXP, K_LEN_HOLD: check_length(rows[i]);
					K_ENV_DOWN, K_ENV_UP:  track_env(rows[i]);
					default:               retrigger(rows[i]);
				endcase
			end
		end
		$display("TEST PASSED");
		$finish;
	end

endmodule

// ==== tb.f ====
+incdir+hw
hw/ch2_pkg.sv
hw/ch2_regs.sv
hw/ch2_control.sv
hw/ch2_down_counter.sv
hw/ch2_freq_timer.sv
hw/ch2_envelope.sv
hw/ch2_waveform.sv
hw/ch2_top.sv
sim/tb_ch2.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_ch2
FRAME_DIV ?= 64
OBJ_DIR   ?= ./obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -j 0

SRCS := $(wildcard hw/*.sv hw/*.svh sim/*.sv)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) tb.f Makefile
	$(VERILATOR) $(VFLAGS) -f tb.f --top-module $(TOP) -GFRAME_DIV=$(FRAME_DIV) \
		--Mdir $(OBJ_DIR) -o V$(TOP)

run: $(BIN)
	$(BIN) | tee $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "TEST PASSED" $(LOG) || { echo "no pass message in $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
